// ==== list.f ====
rtl/uart_line_pkg.sv
rtl/string_frame_pkg.sv
rtl/uart_byte_if.sv
rtl/baud_timer.sv
rtl/uart_serializer.sv
rtl/uart_deserializer.sv
rtl/string_tx_fsm.sv
rtl/string_rx_fsm.sv
rtl/uart_string_top.sv
verification/uart_string_checker.sv
verification/tb_uart_string.sv

// ==== rtl/baud_timer.sv ====
// ------------------------------------------------
// bit period counter
// half_tick mid bit, bit_tick at end of bit
// ------------------------------------------------
`default_nettype none

module baud_timer #(
	parameter int CLKS_PER_BIT = 868
) (
	input  wire  sys_clk,
	input  wire  sys_rst_n,
	input  wire  clear,
	output logic bit_tick,
	output logic half_tick
);

	localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam logic [CNT_W-1:0] LAST = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] HALF = CNT_W'(CLKS_PER_BIT / 2 - 1);

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			cnt <= '0;
		end else if (clear || cnt == LAST) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	assign bit_tick  = (cnt == LAST);
	assign half_tick = (cnt == HALF);

endmodule

`default_nettype wire

// ==== rtl/string_frame_pkg.sv ====
// ------------------------------------------------
// frame marker byte
// transmit framer and receive parser state enums
// ------------------------------------------------
`default_nettype none

package string_frame_pkg;

	// frames open and close with two of these
	localparam logic [7:0] MARKER = 8'h26;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_OPEN1,
		TX_OPEN2,
		TX_CONTENT,
		TX_CLOSE1,
		TX_CLOSE2,
		TX_FINISH
	} tx_state_t;

	typedef enum logic [2:0] {
		RX_HUNT,
		RX_OPEN2,
		RX_CONTENT,
		RX_MARKER_SEEN,
		RX_FINISH
	} rx_state_t;

endpackage

`default_nettype wire

// ==== rtl/string_rx_fsm.sv ====
// ------------------------------------------------
// receive parser
// finds && ... && frames and fills the string buffer
// ------------------------------------------------
`default_nettype none

module string_rx_fsm #(
	parameter int MAX_LEN = 16
) (
	input  wire                             sys_clk,
	input  wire                             sys_rst_n,
	input  wire  [7:0]                      rx_byte,
	input  wire                             rx_valid,
	output logic [8*MAX_LEN-1:0]            rx_string,
	output logic [$clog2(MAX_LEN+1)-1:0]    rx_length,
	output logic                            rx_busy,
	output logic                            rx_done
);

	localparam int LEN_W = $clog2(MAX_LEN + 1);

	string_frame_pkg::rx_state_t state;

	logic is_marker;
	logic open_hit;
	logic store_one;
	logic store_pair;
	logic wr_a;
	logic [7:0] byte_a;
	logic [LEN_W:0] len_sum;
	logic [LEN_W:0] len_plus1;
	logic [LEN_W-1:0] len_next;

	assign is_marker = (rx_byte == string_frame_pkg::MARKER);

	assign open_hit   = (state == string_frame_pkg::RX_OPEN2) && rx_valid && is_marker;
	assign store_one  = (state == string_frame_pkg::RX_CONTENT) && rx_valid && !is_marker;
	// a lone marker inside the content is kept along with the byte after it
	assign store_pair = (state == string_frame_pkg::RX_MARKER_SEEN) && rx_valid && !is_marker;

	assign wr_a   = store_one || store_pair;
	assign byte_a = store_pair ? string_frame_pkg::MARKER : rx_byte;

	// length saturates at MAX_LEN
	assign len_plus1 = {1'b0, rx_length} + (LEN_W+1)'(1);
	assign len_sum   = {1'b0, rx_length} + (store_pair ? (LEN_W+1)'(2) : (LEN_W+1)'(1));
	assign len_next  = (len_sum > (LEN_W+1)'(MAX_LEN)) ? LEN_W'(MAX_LEN) : len_sum[LEN_W-1:0];

	assign rx_busy = (state != string_frame_pkg::RX_HUNT);
	assign rx_done = (state == string_frame_pkg::RX_FINISH);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= string_frame_pkg::RX_HUNT;
		end else begin
			unique case (state)
				string_frame_pkg::RX_HUNT: begin
					if (rx_valid && is_marker) begin
						state <= string_frame_pkg::RX_OPEN2;
					end
				end
				string_frame_pkg::RX_OPEN2: begin
					if (rx_valid) begin
						state <= is_marker ? string_frame_pkg::RX_CONTENT :
							string_frame_pkg::RX_HUNT;
					end
				end
				string_frame_pkg::RX_CONTENT: begin
					if (rx_valid && is_marker) begin
						state <= string_frame_pkg::RX_MARKER_SEEN;
					end
				end
				string_frame_pkg::RX_MARKER_SEEN: begin
					if (rx_valid) begin
						state <= is_marker ? string_frame_pkg::RX_FINISH :
							string_frame_pkg::RX_CONTENT;
					end
				end
				default: state <= string_frame_pkg::RX_HUNT;
			endcase
		end
	end

	//------------------------------------------------
	// string buffer and length
	//------------------------------------------------
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_string <= '0;
			rx_length <= '0;
		end else begin
			if (open_hit) begin
				rx_length <= '0;
			end else if (wr_a) begin
				rx_length <= len_next;
			end
			// lanes past MAX_LEN have no match, so overflow bytes drop out
			for (int i = 0; i < MAX_LEN; i++) begin
				if (wr_a && rx_length == LEN_W'(i)) begin
					rx_string[8*i +: 8] <= byte_a;
				end
				if (store_pair && len_plus1 == (LEN_W+1)'(i)) begin
					rx_string[8*i +: 8] <= rx_byte;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/string_tx_fsm.sv ====
// ------------------------------------------------
// transmit framer
// sends && + content + && through the byte handoff
// ------------------------------------------------
`default_nettype none

module string_tx_fsm #(
	parameter int MAX_LEN = 16
) (
	input  wire                             sys_clk,
	input  wire                             sys_rst_n,
	input  wire  [8*MAX_LEN-1:0]            tx_string,
	input  wire  [$clog2(MAX_LEN+1)-1:0]    tx_length,
	input  wire                             tx_req,
	output logic                            tx_busy,
	output logic                            tx_done,
	uart_byte_if.source                     byte_if
);

	localparam int LEN_W = $clog2(MAX_LEN + 1);

	string_frame_pkg::tx_state_t state;

	logic [8*MAX_LEN-1:0] str_q;
	logic [LEN_W-1:0] len_q;
	logic [LEN_W-1:0] idx;
	logic req_d;
	logic start;
	logic valid_q;
	logic last_byte;

	// rising edge of tx_req with something to send
	assign start = (state == string_frame_pkg::TX_IDLE) && tx_req && !req_d &&
		(tx_length != '0);

	assign last_byte = ((idx + LEN_W'(1)) == len_q);

	assign tx_busy = (state != string_frame_pkg::TX_IDLE);
	assign tx_done = (state == string_frame_pkg::TX_FINISH);

	assign byte_if.valid = valid_q;
	assign byte_if.data  = (state == string_frame_pkg::TX_CONTENT) ? str_q[8*idx +: 8] :
		string_frame_pkg::MARKER;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= string_frame_pkg::TX_IDLE;
			idx     <= '0;
			req_d   <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			req_d <= tx_req;
			// drop the offer once the serializer has taken it
			if (valid_q && byte_if.ready) begin
				valid_q <= 1'b0;
			end
			unique case (state)
				string_frame_pkg::TX_IDLE: begin
					if (start) begin
						state   <= string_frame_pkg::TX_OPEN1;
						idx     <= '0;
						valid_q <= 1'b1;
					end
				end
				string_frame_pkg::TX_OPEN1: begin
					if (byte_if.done) begin
						state   <= string_frame_pkg::TX_OPEN2;
						valid_q <= 1'b1;
					end
				end
				string_frame_pkg::TX_OPEN2: begin
					if (byte_if.done) begin
						state   <= string_frame_pkg::TX_CONTENT;
						valid_q <= 1'b1;
					end
				end
				string_frame_pkg::TX_CONTENT: begin
					if (byte_if.done && last_byte) begin
						state   <= string_frame_pkg::TX_CLOSE1;
						valid_q <= 1'b1;
					end else if (byte_if.done) begin
						idx     <= idx + 1'b1;
						valid_q <= 1'b1;
					end
				end
				string_frame_pkg::TX_CLOSE1: begin
					if (byte_if.done) begin
						state   <= string_frame_pkg::TX_CLOSE2;
						valid_q <= 1'b1;
					end
				end
				string_frame_pkg::TX_CLOSE2: begin
					if (byte_if.done) begin
						state <= string_frame_pkg::TX_FINISH;
					end
				end
				default: state <= string_frame_pkg::TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (start) begin
			str_q <= tx_string;
			len_q <= tx_length;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/uart_byte_if.sv ====
// ------------------------------------------------
// byte handoff from framer to serializer
// ------------------------------------------------
`default_nettype none

interface uart_byte_if;

	logic [uart_line_pkg::DATA_BITS-1:0] data;
	logic                                valid;
	// high while the serializer can take a byte
	logic                                ready;
	// one cycle pulse after the last stop bit
	logic                                done;

	modport source (output data, output valid, input ready, input done);

	modport sink (input data, input valid, output ready, output done);

endinterface

`default_nettype wire

// ==== rtl/uart_deserializer.sv ====
// ------------------------------------------------
// uart receive sampler
// two flop synchroniser, start bit check at mid bit
// data and stop sampled at bit centres
// ------------------------------------------------
`default_nettype none

module uart_deserializer #(
	parameter int CLKS_PER_BIT = 868
) (
	input  wire                                 sys_clk,
	input  wire                                 sys_rst_n,
	input  wire                                 uart_rx,
	output logic [uart_line_pkg::DATA_BITS-1:0] rx_byte,
	output logic                                rx_valid
);

	localparam int CNT_W = $clog2(uart_line_pkg::DATA_BITS);
	localparam logic [CNT_W-1:0] LAST_DATA = CNT_W'(uart_line_pkg::DATA_BITS - 1);

	uart_line_pkg::line_state_t state;

	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic fall;
	logic restart;
	logic bit_tick;
	logic half_tick;
	logic [uart_line_pkg::DATA_BITS-1:0] shift_q;
	logic [CNT_W-1:0] bit_cnt;

	assign fall = rx_prev && !rx_sync;

	// realign the timer to the centre of the start bit
	assign restart = (state == uart_line_pkg::LINE_START) && half_tick;

	baud_timer #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) i_baud_timer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.clear     ((state == uart_line_pkg::LINE_IDLE) || restart),
		.bit_tick  (bit_tick),
		.half_tick (half_tick)
	);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= uart_rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	//------------------------------------------------
	// bit engine
	//------------------------------------------------
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= uart_line_pkg::LINE_IDLE;
			bit_cnt  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			unique case (state)
				uart_line_pkg::LINE_IDLE: begin
					if (fall) begin
						state <= uart_line_pkg::LINE_START;
					end
				end
				uart_line_pkg::LINE_START: begin
					// a glitch shorter than half a bit goes back to idle
					if (half_tick && rx_sync) begin
						state <= uart_line_pkg::LINE_IDLE;
					end else if (half_tick) begin
						state   <= uart_line_pkg::LINE_DATA;
						bit_cnt <= '0;
					end
				end
				uart_line_pkg::LINE_DATA: begin
					if (bit_tick && bit_cnt == LAST_DATA) begin
						state <= uart_line_pkg::LINE_STOP;
					end else if (bit_tick) begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				uart_line_pkg::LINE_STOP: begin
					if (bit_tick) begin
						state    <= uart_line_pkg::LINE_IDLE;
						rx_valid <= rx_sync;
					end
				end
				default: state <= uart_line_pkg::LINE_IDLE;
			endcase
		end
	end

	// lsb arrives first so it shifts in from the top
	always_ff @(posedge sys_clk) begin
		if (bit_tick && state == uart_line_pkg::LINE_DATA) begin
			shift_q <= {rx_sync, shift_q[uart_line_pkg::DATA_BITS-1:1]};
		end
		if (bit_tick && state == uart_line_pkg::LINE_STOP) begin
			rx_byte <= shift_q;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/uart_line_pkg.sv ====
// ------------------------------------------------
// serial line constants for the 8N1 link
// bit engine phase enum shared by tx and rx
// ------------------------------------------------
`default_nettype none

package uart_line_pkg;

	localparam int DATA_BITS    = 8;
	// transmitter holds the line high for two bit times
	localparam int TX_STOP_BITS = 2;

	typedef enum logic [1:0] {
		LINE_IDLE,
		LINE_START,
		LINE_DATA,
		LINE_STOP
	} line_state_t;

endpackage

`default_nettype wire

// ==== rtl/uart_serializer.sv ====
// ------------------------------------------------
// uart transmit shift engine
// start bit, 8 data bits lsb first, stop bits
// ------------------------------------------------
`default_nettype none

module uart_serializer #(
	parameter int CLKS_PER_BIT = 868
) (
	input  wire       sys_clk,
	input  wire       sys_rst_n,
	output logic      uart_tx,
	uart_byte_if.sink byte_if
);

	localparam int CNT_W = $clog2(uart_line_pkg::DATA_BITS);
	localparam logic [CNT_W-1:0] LAST_DATA = CNT_W'(uart_line_pkg::DATA_BITS - 1);
	localparam logic [CNT_W-1:0] LAST_STOP = CNT_W'(uart_line_pkg::TX_STOP_BITS - 1);

	uart_line_pkg::line_state_t state;

	logic [uart_line_pkg::DATA_BITS-1:0] shift_q;
	logic [CNT_W-1:0] bit_cnt;
	logic done_q;
	logic take;
	logic bit_tick;

	assign byte_if.ready = (state == uart_line_pkg::LINE_IDLE);
	assign byte_if.done  = done_q;
	assign take          = byte_if.valid && byte_if.ready;

	// timer runs only while a character is on the line
	baud_timer #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) i_baud_timer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.clear     (state == uart_line_pkg::LINE_IDLE),
		.bit_tick  (bit_tick),
		.half_tick ()
	);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= uart_line_pkg::LINE_IDLE;
			bit_cnt <= '0;
			uart_tx <= 1'b1;
			done_q  <= 1'b0;
		end else begin
			done_q <= 1'b0;
			unique case (state)
				uart_line_pkg::LINE_IDLE: begin
					if (take) begin
						state   <= uart_line_pkg::LINE_START;
						uart_tx <= 1'b0;
						bit_cnt <= '0;
					end
				end
				uart_line_pkg::LINE_START: begin
					if (bit_tick) begin
						state   <= uart_line_pkg::LINE_DATA;
						uart_tx <= shift_q[0];
					end
				end
				uart_line_pkg::LINE_DATA: begin
					if (bit_tick && bit_cnt == LAST_DATA) begin
						state   <= uart_line_pkg::LINE_STOP;
						uart_tx <= 1'b1;
						bit_cnt <= '0;
					end else if (bit_tick) begin
						uart_tx <= shift_q[0];
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				uart_line_pkg::LINE_STOP: begin
					if (bit_tick && bit_cnt == LAST_STOP) begin
						state  <= uart_line_pkg::LINE_IDLE;
						done_q <= 1'b1;
					end else if (bit_tick) begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				default: state <= uart_line_pkg::LINE_IDLE;
			endcase
		end
	end

	// bit 0 of the shift register is the next data bit out
	always_ff @(posedge sys_clk) begin
		if (take) begin
			shift_q <= byte_if.data;
		end else if (bit_tick && (state == uart_line_pkg::LINE_START ||
				state == uart_line_pkg::LINE_DATA)) begin
			shift_q <= shift_q >> 1;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/uart_string_top.sv ====
// ------------------------------------------------
// uart string framing subsystem top level
// transmit framer + serializer, deserializer + parser
// ------------------------------------------------
`default_nettype none

module uart_string_top #(
	parameter int CLKS_PER_BIT = 868,
	parameter int MAX_LEN      = 16
) (
	input  wire                             sys_clk,
	input  wire                             sys_rst_n,
	input  wire  [8*MAX_LEN-1:0]            tx_string,
	input  wire  [$clog2(MAX_LEN+1)-1:0]    tx_length,
	input  wire                             tx_req,
	output logic                            tx_busy,
	output logic                            tx_done,
	output logic [8*MAX_LEN-1:0]            rx_string,
	output logic [$clog2(MAX_LEN+1)-1:0]    rx_length,
	output logic                            rx_busy,
	output logic                            rx_done,
	input  wire                             uart_rx,
	output logic                            uart_tx
);

	logic [7:0] rx_byte;
	logic       rx_valid;

	uart_byte_if tx_byte_if ();

	//------------------------------------------------
	// transmit path
	//------------------------------------------------
	string_tx_fsm #(
		.MAX_LEN (MAX_LEN)
	) i_string_tx_fsm (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.byte_if   (tx_byte_if.source)
	);

	uart_serializer #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) i_uart_serializer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.uart_tx   (uart_tx),
		.byte_if   (tx_byte_if.sink)
	);

	//------------------------------------------------
	// receive path
	//------------------------------------------------
	uart_deserializer #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) i_uart_deserializer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.uart_rx   (uart_rx),
		.rx_byte   (rx_byte),
		.rx_valid  (rx_valid)
	);

	string_rx_fsm #(
		.MAX_LEN (MAX_LEN)
	) i_string_rx_fsm (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_byte   (rx_byte),
		.rx_valid  (rx_valid),
		.rx_string (rx_string),
		.rx_length (rx_length),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done)
	);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the uart string testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	-f list.f \
	--top-module tb_uart_string \
	-o tb_uart_string

./obj_dir/tb_uart_string | tee sim.log

if grep -q "Something failed" sim.log; then
	exit 1
fi
grep -q "Everything OK" sim.log

// ==== verification/tb_uart_string.sv ====
// ------------------------------------------------
// testbench for the uart string subsystem
// clock, reset, watchdog, stimulus, rx line model
// ------------------------------------------------
`default_nettype none

module tb_uart_string;

	localparam int CLKS_PER_BIT = 16;
	localparam int MAX_LEN      = 16;
	localparam int LEN_W        = $clog2(MAX_LEN + 1);
	localparam int TX_FRAMES    = 20;
	localparam int RX_FRAMES    = 10;
	localparam int NOISE_FRAMES = 5;
	localparam int OVF_LEN      = 20;
	// upper bound on characters sent over the whole run
	localparam int TOTAL_CHARS  = (TX_FRAMES + 1) * (MAX_LEN + 4) +
		(RX_FRAMES + NOISE_FRAMES) * (MAX_LEN + 8) + OVF_LEN + 4;
	localparam longint TIMEOUT  = longint'(TOTAL_CHARS) * 11 * CLKS_PER_BIT * 100 * 2;

	logic                 sys_clk;
	logic                 sys_rst_n;
	logic [8*MAX_LEN-1:0] tx_string;
	logic [LEN_W-1:0]     tx_length;
	logic                 tx_req;
	logic                 uart_rx;
	logic                 tx_busy;
	logic                 tx_done;
	logic [8*MAX_LEN-1:0] rx_string;
	logic [LEN_W-1:0]     rx_length;
	logic                 rx_busy;
	logic                 rx_done;
	logic                 uart_tx;

	int tb_errors = 0;

	uart_string_top #(
		.CLKS_PER_BIT (CLKS_PER_BIT),
		.MAX_LEN      (MAX_LEN)
	) i_dut (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.rx_string (rx_string),
		.rx_length (rx_length),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done),
		.uart_rx   (uart_rx),
		.uart_tx   (uart_tx)
	);

	uart_string_checker #(
		.CLKS_PER_BIT (CLKS_PER_BIT),
		.MAX_LEN      (MAX_LEN)
	) i_checker (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done),
		.rx_string (rx_string),
		.rx_length (rx_length),
		.uart_tx   (uart_tx)
	);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	initial begin
		#(TIMEOUT);
		$display("watchdog expired before the tests finished");
		$display("Something failed");
		$finish;
	end

	//------------------------------------------------
	// helpers
	//------------------------------------------------
	function automatic logic [7:0] plain_byte();
		logic [7:0] b;
		do begin
			b = 8'($urandom);
		end while (b == string_frame_pkg::MARKER);
		return b;
	endfunction

	// 8N1 line model that starts and ends on a falling clock edge
	task automatic send_char(input logic [7:0] b);
		uart_rx = 1'b0;
		repeat (CLKS_PER_BIT) @(negedge sys_clk);
		for (int i = 0; i < 8; i++) begin
			uart_rx = b[i];
			repeat (CLKS_PER_BIT) @(negedge sys_clk);
		end
		uart_rx = 1'b1;
		repeat (CLKS_PER_BIT) @(negedge sys_clk);
	endtask

	// frame into uart_rx and wait for the parser to report it
	task automatic receive_frame(input logic [8*OVF_LEN-1:0] s, input int len);
		int target;
		int kept;
		target = i_checker.rx_frames + 1;
		kept   = (len > MAX_LEN) ? MAX_LEN : len;
		i_checker.expect_rx_frame(s[8*MAX_LEN-1:0], kept);
		send_char(string_frame_pkg::MARKER);
		send_char(string_frame_pkg::MARKER);
		for (int i = 0; i < len; i++) begin
			send_char(s[8*i +: 8]);
		end
		send_char(string_frame_pkg::MARKER);
		send_char(string_frame_pkg::MARKER);
		while (i_checker.rx_frames < target) @(negedge sys_clk);
	endtask

	task automatic request_tx(input logic [8*MAX_LEN-1:0] s, input int len);
		tx_string = s;
		tx_length = LEN_W'(len);
		tx_req    = 1'b1;
		@(negedge sys_clk);
		tx_req = 1'b0;
	endtask

	// transmitter must stay idle for the given number of cycles
	task automatic check_tx_idle(input int cycles, input string cause);
		int busy_cycles;
		busy_cycles = 0;
		repeat (cycles) begin
			if (tx_busy) begin
				busy_cycles++;
			end
			@(negedge sys_clk);
		end
		if (busy_cycles != 0) begin
			$display("tx_busy was high for %0d cycles after %s", busy_cycles, cause);
			tb_errors++;
		end
	endtask

	task automatic report_test(input string name, input int start_errors);
		$display("test %s: %0d errors", name,
			i_checker.errors + tb_errors - start_errors);
	endtask

	//------------------------------------------------
	// stimulus
	//------------------------------------------------
	initial begin : stimulus
		logic [8*MAX_LEN-1:0] s;
		logic [8*OVF_LEN-1:0] rs;
		int len;
		int pos;
		int mark;
		int total;

		sys_rst_n = 1'b0;
		tx_string = '0;
		tx_length = '0;
		tx_req    = 1'b0;
		uart_rx   = 1'b1;
		void'($urandom(32'h116e));
		repeat (3) @(negedge sys_clk);
		sys_rst_n = 1'b1;
		repeat (4) @(negedge sys_clk);
		report_test("reset", 0);

		mark = i_checker.errors + tb_errors;
		for (int n = 0; n < TX_FRAMES; n++) begin
			len = $urandom_range(1, MAX_LEN);
			for (int i = 0; i < MAX_LEN; i++) s[8*i +: 8] = plain_byte();
			i_checker.expect_tx_frame(s, len);
			request_tx(s, len);
			while (!tx_done) @(negedge sys_clk);
			@(negedge sys_clk);
		end
		// zero length must not start a frame
		request_tx(s, 0);
		check_tx_idle(4 * CLKS_PER_BIT, "a request of length 0");
		report_test("random transmit", mark);

		mark = i_checker.errors + tb_errors;
		for (int n = 0; n < RX_FRAMES; n++) begin
			len = $urandom_range(1, MAX_LEN);
			for (int i = 0; i < OVF_LEN; i++) rs[8*i +: 8] = plain_byte();
			receive_frame(rs, len);
		end
		report_test("random receive", mark);

		mark = i_checker.errors + tb_errors;
		for (int n = 0; n < NOISE_FRAMES; n++) begin
			repeat (3) send_char(plain_byte());
			if (rx_busy) begin
				$display("rx_busy went high on noise bytes before the frame");
				tb_errors++;
			end
			len = $urandom_range(3, MAX_LEN);
			for (int i = 0; i < OVF_LEN; i++) rs[8*i +: 8] = plain_byte();
			pos = $urandom_range(1, len - 2);
			rs[8*pos +: 8] = string_frame_pkg::MARKER;
			receive_frame(rs, len);
		end
		report_test("noise and embedded marker", mark);

		mark = i_checker.errors + tb_errors;
		for (int i = 0; i < OVF_LEN; i++) rs[8*i +: 8] = plain_byte();
		receive_frame(rs, OVF_LEN);
		report_test("receive overflow", mark);

		mark = i_checker.errors + tb_errors;
		len = 4;
		for (int i = 0; i < MAX_LEN; i++) s[8*i +: 8] = plain_byte();
		i_checker.expect_tx_frame(s, len);
		request_tx(s, len);
		repeat (50) @(negedge sys_clk);
		request_tx(~s, MAX_LEN);
		repeat (300) @(negedge sys_clk);
		request_tx(~s, 2);
		while (!tx_done) @(negedge sys_clk);
		@(negedge sys_clk);
		check_tx_idle(4 * CLKS_PER_BIT, "the last accepted frame");
		if (i_checker.tx_frames != TX_FRAMES + 1) begin
			$display("tx_done count did not match the number of accepted frames");
			tb_errors++;
		end
		report_test("request while busy", mark);

		total = i_checker.errors + tb_errors;
		$display("tx frames %0d, rx frames %0d, errors %0d",
			i_checker.tx_frames, i_checker.rx_frames, total);
		if (total == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/uart_string_checker.sv ====
// ------------------------------------------------
// monitor for the uart string subsystem
// decodes uart_tx, checks frames and received strings
// ------------------------------------------------
`default_nettype none

module uart_string_checker #(
	parameter int CLKS_PER_BIT = 16,
	parameter int MAX_LEN      = 16
) (
	input wire                         sys_clk,
	input wire                         sys_rst_n,
	input wire                         tx_busy,
	input wire                         tx_done,
	input wire                         rx_busy,
	input wire                         rx_done,
	input wire [8*MAX_LEN-1:0]         rx_string,
	input wire [$clog2(MAX_LEN+1)-1:0] rx_length,
	input wire                         uart_tx
);

	// expected line bytes and received frames
	logic [7:0]           exp_tx_q[$];
	logic [8*MAX_LEN-1:0] exp_rx_str_q[$];
	int                   exp_rx_len_q[$];

	int errors       = 0;
	int tx_expected  = 0;
	int tx_frames    = 0;
	int rx_frames    = 0;

	task automatic expect_tx_frame(input logic [8*MAX_LEN-1:0] s, input int len);
		exp_tx_q.push_back(string_frame_pkg::MARKER);
		exp_tx_q.push_back(string_frame_pkg::MARKER);
		for (int i = 0; i < len; i++) begin
			exp_tx_q.push_back(s[8*i +: 8]);
		end
		exp_tx_q.push_back(string_frame_pkg::MARKER);
		exp_tx_q.push_back(string_frame_pkg::MARKER);
		tx_expected++;
	endtask

	task automatic expect_rx_frame(input logic [8*MAX_LEN-1:0] s, input int len);
		exp_rx_str_q.push_back(s);
		exp_rx_len_q.push_back(len);
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error %s after reset: expected 0x%h got 0x%h", name, exp, got);
			errors++;
		end
	endtask

	//------------------------------------------------
	// per cycle checks at the falling edge
	//------------------------------------------------
	always @(negedge sys_clk) begin : watch
		static bit   reset_checked = 0;
		static bit   done_seen     = 0;
		static bit   rx_done_seen  = 0;
		static bit   dec_active    = 0;
		static int   wait_cnt      = 0;
		static int   phase         = 0;
		static logic [7:0] shreg   = '0;
		logic [7:0] exp_b;
		logic [8*MAX_LEN-1:0] exp_s;
		int exp_len;

		if (sys_rst_n) begin
			if (!reset_checked) begin
				reset_checked = 1;
				compare_bit("tx_busy", tx_busy, 1'b0);
				compare_bit("tx_done", tx_done, 1'b0);
				compare_bit("rx_busy", rx_busy, 1'b0);
				compare_bit("rx_done", rx_done, 1'b0);
				compare_bit("uart_tx", uart_tx, 1'b1);
			end

			// line decoder sampling at bit centres
			if (!dec_active) begin
				if (!uart_tx) begin
					dec_active = 1;
					wait_cnt   = CLKS_PER_BIT / 2 - 1;
					phase      = 0;
				end
			end else if (wait_cnt > 0) begin
				wait_cnt--;
			end else if (phase == 0) begin
				if (uart_tx) begin
					$display("start bit on uart_tx did not hold low");
					errors++;
					dec_active = 0;
				end else begin
					wait_cnt = CLKS_PER_BIT - 1;
					phase    = 1;
				end
			end else if (phase <= 8) begin
				shreg    = {uart_tx, shreg[7:1]};
				wait_cnt = CLKS_PER_BIT - 1;
				phase++;
			end else begin
				dec_active = 0;
				if (!uart_tx) begin
					$display("stop bit on uart_tx was low");
					errors++;
				end
				if (exp_tx_q.size() == 0) begin
					$display("byte 0x%02h appeared on uart_tx with no frame pending", shreg);
					errors++;
				end else begin
					exp_b = exp_tx_q.pop_front();
					if (shreg !== exp_b) begin
						$display("error uart_tx byte: expected 0x%02h got 0x%02h", exp_b, shreg);
						errors++;
					end
				end
			end

			// transmit handshake
			if (done_seen && tx_busy) begin
				$display("tx_busy still high after tx_done");
				errors++;
			end
			done_seen = tx_done;
			if (tx_done) begin
				if (tx_frames >= tx_expected) begin
					$display("tx_done pulsed with no frame pending");
					errors++;
				end else if (exp_tx_q.size() != 0) begin
					$display("tx_done came before the whole frame was seen on uart_tx");
					errors++;
				end
				tx_frames++;
			end

			// receive handshake
			if (rx_done_seen && rx_busy) begin
				$display("rx_busy still high after rx_done");
				errors++;
			end
			rx_done_seen = rx_done;

			// receive result
			if (rx_done) begin
				if (exp_rx_len_q.size() == 0) begin
					$display("rx_done pulsed with no frame expected");
					errors++;
				end else begin
					exp_s   = exp_rx_str_q.pop_front();
					exp_len = exp_rx_len_q.pop_front();
					if (int'(rx_length) != exp_len) begin
						$display("error rx_length: expected 0x%h got 0x%h", exp_len, rx_length);
						errors++;
					end
					for (int i = 0; i < exp_len; i++) begin
						if (rx_string[8*i +: 8] !== exp_s[8*i +: 8]) begin
							$display("error rx_string byte %0d: expected 0x%02h got 0x%02h",
								i, exp_s[8*i +: 8], rx_string[8*i +: 8]);
							errors++;
						end
					end
				end
				rx_frames++;
			end
		end
	end

endmodule

`default_nettype wire
